/* filelist.f */
+incdir+.
pipe_pkg.sv
hazard_detect.sv
mem_credit_tracker.sv
pipeline_control.sv
pipe_ctrl_top.sv
pipe_ctrl_assertions.sv
tb_pipe_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pipe_ctrl
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= TEST PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module tb_pipe_ctrl;

  import pipe_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DLY    = 2;
  localparam int CHECK_DLY    = 36; // just before the next rising edge
  localparam int RESET_CYCLES = 10;
  localparam int N_CYCLES     = 3000;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + N_CYCLES + 50) * CLK_PERIOD;

  logic       clk;
  logic       rst;
  reg_idx_t   id_rs1;
  reg_idx_t   id_rs2;
  reg_idx_t   ex_rd;
  logic       ex_is_load;
  logic       ex_jump_taken;
  logic       md_start;
  logic       if_req;
  logic       rsp_if;
  logic       credit_if;
  logic       mem_req;
  logic       rsp_mem;
  logic       credit_mem;
  logic       trap_stall;
  logic       trap_flush;
  logic       issue_if;
  logic       issue_mem;
  stage_vec_t stall;
  stage_vec_t flush;

  logic [15:0] lfsr;
  int          n_checks;
  int          n_errors;

  // reference model, index 0 is the fetch port and 1 the data port
  int   m_cred [2];
  logic m_outst [2];
  int   m_owed [2]; // credits the arbiter still has to give back
  int   m_md_left;  // mul/div busy cycles left after the current one

  pipe_ctrl_top UUT (
    .clk(clk), .rst(rst),
    .id_rs1_i(id_rs1), .id_rs2_i(id_rs2), .ex_rd_i(ex_rd),
    .ex_is_load_i(ex_is_load), .ex_jump_taken_i(ex_jump_taken), .md_start_i(md_start),
    .if_req_i(if_req), .rsp_if_i(rsp_if), .credit_if_i(credit_if),
    .mem_req_i(mem_req), .rsp_mem_i(rsp_mem), .credit_mem_i(credit_mem),
    .trap_stall_i(trap_stall), .trap_flush_i(trap_flush),
    .issue_if_o(issue_if), .issue_mem_o(issue_mem),
    .stall_o(stall), .flush_o(flush)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic chance(input int k); // probability 1 / 2**k
    return rand_bits(k) == 16'd0;
  endfunction

  task automatic check_val(input string name, input logic [5:0] exp, input logic [5:0] act);
    n_checks++;
    assert (act === exp) else begin
      n_errors++;
      $display("FAIL %0t ns %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic reset_model();
    for (int p = 0; p < 2; p++) begin
      m_cred[p]  = `CREDIT_MAX;
      m_outst[p] = 1'b0;
      m_owed[p]  = 0;
    end
    m_md_left = 0;
  endtask

  task automatic drive_idle();
    id_rs1        = '0;
    id_rs2        = '0;
    ex_rd         = '0;
    ex_is_load    = 1'b0;
    ex_jump_taken = 1'b0;
    md_start      = 1'b0;
    if_req        = 1'b0;
    rsp_if        = 1'b0;
    credit_if     = 1'b0;
    mem_req       = 1'b0;
    rsp_mem       = 1'b0;
    credit_mem    = 1'b0;
    trap_stall    = 1'b0;
    trap_flush    = 1'b0;
  endtask

  task automatic drive_random();
    id_rs1        = reg_idx_t'(rand_bits(2)); // few indices, so matches are common
    id_rs2        = reg_idx_t'(rand_bits(2));
    ex_rd         = reg_idx_t'(rand_bits(2));
    ex_is_load    = chance(1);
    ex_jump_taken = chance(3);
    md_start      = chance(4);
    trap_flush    = chance(4);
    trap_stall    = chance(4);
    if_req        = chance(1);
    mem_req       = chance(2);
    // responder answers only an open request, credit comes after its response
    rsp_if     = !chance(2) && m_outst[0];
    rsp_mem    = !chance(2) && m_outst[1];
    credit_if  = chance(2) && (m_owed[0] > 0); // slow returns drain the credits
    credit_mem = chance(2) && (m_owed[1] > 0);
  endtask

  // expected codes from the priority table, then advance the model
  task automatic check_cycle();
    logic       req [2];
    logic       rsp [2];
    logic       cret [2];
    logic       can [2];
    logic       st_if;
    logic       st_mem;
    logic       fw;
    logic       lu;
    logic       mdb;
    stage_vec_t exp_stall;
    stage_vec_t exp_flush;
    req  = '{if_req, mem_req};
    rsp  = '{rsp_if, rsp_mem};
    cret = '{credit_if, credit_mem};
    for (int p = 0; p < 2; p++) begin
      can[p] = req[p] && !m_outst[p] && ((m_cred[p] != 0) || cret[p]);
    end
    st_if  = if_req && !can[0];
    st_mem = (mem_req && !can[1]) || (m_outst[1] && !rsp_mem);
    fw     = m_outst[0] && !rsp_if;
    lu     = ex_is_load && (ex_rd != '0) && ((ex_rd == id_rs1) || (ex_rd == id_rs2));
    mdb    = (m_md_left > 0) || md_start;

    if (st_mem) begin
      exp_stall = `RAM_MEM_STALL;
      exp_flush = `RAM_MEM_FLUSH;
    end else if (st_if) begin
      exp_stall = `RAM_IF_STALL;
      exp_flush = `RAM_IF_FLUSH;
    end else if (trap_flush) begin
      exp_stall = `TRAP_FLUSH_STALL;
      exp_flush = `TRAP_FLUSH_FLUSH;
    end else if (trap_stall) begin
      exp_stall = `TRAP_STALL_STALL;
      exp_flush = `TRAP_STALL_FLUSH;
    end else if (ex_jump_taken) begin
      exp_stall = `JUMP_STALL;
      exp_flush = `JUMP_FLUSH;
    end else if (mdb) begin
      exp_stall = `MD_STALL;
      exp_flush = `MD_FLUSH;
    end else if (lu) begin
      exp_stall = `LU_STALL;
      exp_flush = `LU_FLUSH;
    end else if (fw) begin
      exp_stall = `FETCH_WAIT_STALL;
      exp_flush = 6'b000000;
    end else begin
      exp_stall = '0;
      exp_flush = '0;
    end

    check_val("stall_o", exp_stall, stall);
    check_val("flush_o", exp_flush, flush);
    check_val("issue_if_o", {5'b0, can[0]}, {5'b0, issue_if});
    check_val("issue_mem_o", {5'b0, can[1]}, {5'b0, issue_mem});

    for (int p = 0; p < 2; p++) begin
      if (rsp[p] && m_outst[p]) m_owed[p]++; // response frees a credit on the arbiter side
      if (cret[p]) begin
        m_owed[p]--;
        m_cred[p]++;
      end
      if (can[p]) m_cred[p]--;
      if (can[p]) begin
        m_outst[p] = 1'b1;
      end else if (rsp[p]) begin
        m_outst[p] = 1'b0;
      end
    end
    if (m_md_left > 0) begin
      m_md_left--;
    end else if (md_start) begin
      m_md_left = `MD_CYCLES;
    end
  endtask

  initial begin
    lfsr     = 16'd19739;
    n_checks = 0;
    n_errors = 0;
    rst      = 1'b1;
    drive_idle();
    reset_model();
    for (int k = 1; k <= RESET_CYCLES; k++) begin
      @(posedge clk);
      #(DRIVE_DLY);
      if (k == RESET_CYCLES) rst = 1'b0;
      #(CHECK_DLY);
      if (rst) begin
        check_val("stall_o", 6'b000000, stall);
        check_val("flush_o", `RESET_FLUSH, flush);
      end else begin
        // first idle cycle, credits must be full
        check_val("credit_if", 6'(`CREDIT_MAX), {3'b0, UUT.u_credit.credit_q[0]});
        check_val("credit_mem", 6'(`CREDIT_MAX), {3'b0, UUT.u_credit.credit_q[1]});
        check_cycle();
      end
    end

    repeat (N_CYCLES) begin
      @(posedge clk);
      #(DRIVE_DLY);
      drive_random();
      #(CHECK_DLY);
      check_cycle();
    end

    n_errors += UUT.u_assertions.fail_cnt; // bound property failures
    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the stimulus did not complete", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* pipe_ctrl_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

// properties on the credit tracker and the stall/flush combiner
module pipe_ctrl_assertions (
  input  wire logic           clk,
  input  wire logic           rst,
  input  pipe_pkg::stage_vec_t flush_i,
  input  pipe_pkg::credit_t   credit_if_i,
  input  pipe_pkg::credit_t   credit_mem_i,
  input  wire logic           rsp_if_i,
  input  wire logic           rsp_mem_i,
  input  wire logic           issue_if_i,
  input  wire logic           issue_mem_i
);

  import pipe_pkg::*;

  int fail_cnt = 0; // read by the testbench at the end

  logic pend_if_q;  // fetch response still owed, seen from the port
  logic pend_mem_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_if_q  <= 1'b0;
      pend_mem_q <= 1'b0;
    end else begin
      if (issue_if_i) begin
        pend_if_q <= 1'b1;
      end else if (rsp_if_i) begin
        pend_if_q <= 1'b0;
      end
      if (issue_mem_i) begin
        pend_mem_q <= 1'b1;
      end else if (rsp_mem_i) begin
        pend_mem_q <= 1'b0;
      end
    end
  end

  reset_flush_a: assert property (@(posedge clk) rst |-> (flush_i == `RESET_FLUSH))
    else begin
      fail_cnt++;
      $error("flush vector is not the reset code while rst is high");
    end

  credit_max_a: assert property (@(posedge clk) disable iff (rst)
    (credit_if_i <= `CREDIT_MAX) && (credit_mem_i <= `CREDIT_MAX))
    else begin
      fail_cnt++;
      $error("credit counter above its maximum");
    end

  // one response in flight per port
  issue_outst_a: assert property (@(posedge clk) disable iff (rst)
    !(issue_if_i && pend_if_q) && !(issue_mem_i && pend_mem_q))
    else begin
      fail_cnt++;
      $error("request issued while a response is still outstanding");
    end

endmodule

bind pipe_ctrl_top pipe_ctrl_assertions u_assertions (
  .clk(clk), .rst(rst), .flush_i(flush_o),
  .credit_if_i(u_credit.credit_q[0]), .credit_mem_i(u_credit.credit_q[1]),
  .rsp_if_i(rsp_if_i), .rsp_mem_i(rsp_mem_i),
  .issue_if_i(issue_if_o), .issue_mem_i(issue_mem_o)
);

`default_nettype wire

/* pipe_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top (
  input  wire logic            clk,
  input  wire logic            rst,
  // hazard inputs
  input  pipe_pkg::reg_idx_t   id_rs1_i,
  input  pipe_pkg::reg_idx_t   id_rs2_i,
  input  pipe_pkg::reg_idx_t   ex_rd_i,
  input  wire logic            ex_is_load_i,
  input  wire logic            ex_jump_taken_i,
  input  wire logic            md_start_i,
  // memory ports
  input  wire logic            if_req_i,
  input  wire logic            rsp_if_i,
  input  wire logic            credit_if_i,
  input  wire logic            mem_req_i,
  input  wire logic            rsp_mem_i,
  input  wire logic            credit_mem_i,
  // traps from writeback
  input  wire logic            trap_stall_i,
  input  wire logic            trap_flush_i,
  output logic                 issue_if_o,
  output logic                 issue_mem_o,
  output pipe_pkg::stage_vec_t stall_o,
  output pipe_pkg::stage_vec_t flush_o
);

  logic load_use;
  logic jump;
  logic md_busy;
  logic ram_stall_if;
  logic ram_stall_mem;
  logic fetch_wait;

  hazard_detect u_hazard (
    .clk(clk), .rst(rst),
    .id_rs1_i(id_rs1_i), .id_rs2_i(id_rs2_i), .ex_rd_i(ex_rd_i),
    .ex_is_load_i(ex_is_load_i), .ex_jump_taken_i(ex_jump_taken_i),
    .md_start_i(md_start_i),
    .load_use_o(load_use), .jump_o(jump), .md_busy_o(md_busy)
  );

  mem_credit_tracker u_credit (
    .clk(clk), .rst(rst),
    .if_req_i(if_req_i), .rsp_if_i(rsp_if_i), .credit_if_i(credit_if_i),
    .mem_req_i(mem_req_i), .rsp_mem_i(rsp_mem_i), .credit_mem_i(credit_mem_i),
    .issue_if_o(issue_if_o), .issue_mem_o(issue_mem_o),
    .ram_stall_if_o(ram_stall_if), .ram_stall_mem_o(ram_stall_mem),
    .fetch_wait_o(fetch_wait)
  );

  pipeline_control u_ctrl (
    .rst(rst),
    .ram_stall_if_i(ram_stall_if), .ram_stall_mem_i(ram_stall_mem),
    .fetch_wait_i(fetch_wait),
    .trap_stall_i(trap_stall_i), .trap_flush_i(trap_flush_i),
    .jump_i(jump), .md_busy_i(md_busy), .load_use_i(load_use),
    .stall_o(stall_o), .flush_o(flush_o)
  );

endmodule

`default_nettype wire

/* pipeline_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module pipeline_control (
  input  wire logic          rst,
  // stall sources, listed from memory side back
  input  wire logic          ram_stall_if_i,
  input  wire logic          ram_stall_mem_i,
  input  wire logic          fetch_wait_i,
  input  wire logic          trap_stall_i,   // from WB
  input  wire logic          trap_flush_i,   // from WB
  input  wire logic          jump_i,         // from EX
  input  wire logic          md_busy_i,      // from EX
  input  wire logic          load_use_i,     // from ID
  output pipe_pkg::stage_vec_t stall_o,
  output pipe_pkg::stage_vec_t flush_o
);

  // later stage wins, memory first
  always_comb begin
    if (rst) begin
      stall_o = '0;
      flush_o = `RESET_FLUSH; // clear everything but WB
    end else if (ram_stall_mem_i) begin
      stall_o = `RAM_MEM_STALL;
      flush_o = `RAM_MEM_FLUSH; // bubble into MEM/WB
    end else if (ram_stall_if_i) begin
      stall_o = `RAM_IF_STALL;
      flush_o = `RAM_IF_FLUSH;
    end else if (trap_flush_i) begin
      // redirect to handler, drop younger instructions
      stall_o = `TRAP_FLUSH_STALL;
      flush_o = `TRAP_FLUSH_FLUSH;
    end else if (trap_stall_i) begin
      stall_o = `TRAP_STALL_STALL; // freeze the whole pipe
      flush_o = `TRAP_STALL_FLUSH;
    end else if (jump_i) begin
      stall_o = `JUMP_STALL;
      flush_o = `JUMP_FLUSH; // kill the two wrong-path fetches
    end else if (md_busy_i) begin
      stall_o = `MD_STALL;
      flush_o = `MD_FLUSH;
    end else if (load_use_i) begin
      // hold ID one cycle, bubble into EX
      stall_o = `LU_STALL;
      flush_o = `LU_FLUSH;
    end else if (fetch_wait_i) begin
      stall_o = `FETCH_WAIT_STALL;
      flush_o = `FETCH_WAIT_FLUSH;
    end else begin
      stall_o = '0;
      flush_o = '0;
    end
  end

endmodule

`default_nettype wire

/* mem_credit_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module mem_credit_tracker (
  input  wire logic clk,
  input  wire logic rst,
  // fetch port
  input  wire logic if_req_i,
  input  wire logic rsp_if_i,
  input  wire logic credit_if_i,
  // data port
  input  wire logic mem_req_i,
  input  wire logic rsp_mem_i,
  input  wire logic credit_mem_i,
  output logic      issue_if_o,
  output logic      issue_mem_o,
  output logic      ram_stall_if_o,
  output logic      ram_stall_mem_o,
  output logic      fetch_wait_o
);

  import pipe_pkg::*;

  localparam int PORT_IF  = 0;
  localparam int PORT_MEM = 1;

  logic [1:0]        req;
  logic [1:0]        rsp;
  logic [1:0]        credit_ret;
  logic [1:0]        can_issue;
  logic [1:0]        outst_q;   // one response in flight per port
  credit_t [1:0]     credit_q;

  assign req        = {mem_req_i, if_req_i};
  assign rsp        = {rsp_mem_i, rsp_if_i};
  assign credit_ret = {credit_mem_i, credit_if_i};

  for (genvar p = 0; p < 2; p++) begin : g_port
    credit_t credit_sum;

    // a credit coming back this cycle can be spent at once
    assign can_issue[p] = req[p] && !outst_q[p] &&
                          ((credit_q[p] != '0) || credit_ret[p]);

    assign credit_sum = credit_q[p] + credit_t'(credit_ret[p]) - credit_t'(can_issue[p]);

    always_ff @(posedge clk) begin
      if (rst) begin
        credit_q[p] <= credit_t'(`CREDIT_MAX);
        outst_q[p]  <= 1'b0;
      end else begin
        credit_q[p] <= credit_sum; // arbiter returns only what was issued

        if (can_issue[p]) begin
          outst_q[p] <= 1'b1;
        end else if (rsp[p]) begin
          outst_q[p] <= 1'b0; // response closes the wait
        end
      end
    end
  end

  assign issue_if_o  = can_issue[PORT_IF];
  assign issue_mem_o = can_issue[PORT_MEM];

  // fetch side blocked on credit or on the previous fetch
  assign ram_stall_if_o = if_req_i && !can_issue[PORT_IF];

  // data side also waits for its own response
  assign ram_stall_mem_o = (mem_req_i && !can_issue[PORT_MEM]) ||
                           (outst_q[PORT_MEM] && !rsp_mem_i);

  assign fetch_wait_o = outst_q[PORT_IF] && !rsp_if_i;

endmodule

`default_nettype wire

/* hazard_detect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module hazard_detect (
  input  wire                logic clk,
  input  wire                logic rst,
  input  pipe_pkg::reg_idx_t id_rs1_i,
  input  pipe_pkg::reg_idx_t id_rs2_i,
  input  pipe_pkg::reg_idx_t ex_rd_i,
  input  wire                logic ex_is_load_i,
  input  wire                logic ex_jump_taken_i,
  input  wire                logic md_start_i,
  output logic               load_use_o,
  output logic               jump_o,
  output logic               md_busy_o
);

  import pipe_pkg::*;

  localparam int MD_CNT_W = $clog2(`MD_CYCLES + 1);

  md_state_t             md_state_q;
  md_state_t             md_state_d;
  logic [MD_CNT_W-1:0]   md_cnt_q; // busy cycles left after this one
  logic [MD_CNT_W-1:0]   md_cnt_d;
  logic                  rd_hit;

  // load in EX whose destination feeds the instruction in ID
  assign rd_hit     = (ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i);
  assign load_use_o = ex_is_load_i && (ex_rd_i != '0) && rd_hit; // x0 never hazards

  assign jump_o = ex_jump_taken_i; // resolved in EX

  always_comb begin
    md_state_d = md_state_q;
    md_cnt_d   = md_cnt_q;
    case (md_state_q)
      MD_IDLE: begin
        if (md_start_i) begin
          md_state_d = MD_BUSY;
          md_cnt_d   = MD_CNT_W'(`MD_CYCLES - 1);
        end
      end
      MD_BUSY: begin
        if (md_cnt_q == '0) begin
          md_state_d = MD_IDLE; // last busy cycle
        end else begin
          md_cnt_d = md_cnt_q - 1'b1;
        end
      end
      default: md_state_d = MD_IDLE;
    endcase
  end

  // start cycle already holds EX, then MD_CYCLES more
  assign md_busy_o = (md_state_q == MD_BUSY) || md_start_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      md_state_q <= MD_IDLE;
      md_cnt_q   <= '0;
    end else begin
      md_state_q <= md_state_d;
      md_cnt_q   <= md_cnt_d;
    end
  end

endmodule

`default_nettype wire

/* pipe_pkg.sv */
`default_nettype none

`include "pipe_consts.svh"

package pipe_pkg;

  // one bit per pipeline register, bit 0 is PC
  typedef logic [`STAGES-1:0] stage_vec_t;

  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // credit count of one memory port
  typedef logic [`CREDIT_W-1:0] credit_t;

  // multi-cycle mul/div sequencer
  typedef enum logic {
    MD_IDLE,
    MD_BUSY
  } md_state_t;

endpackage

`default_nettype wire

/* pipe_consts.svh */
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

`define STAGES      6 // PC, IF/ID, ID/EX, EX/MEM, MEM/WB, WB
`define REG_IDX_W   5
`define CREDIT_MAX  2 // credits per port after reset, 1..7
`define CREDIT_W    3
`define MD_CYCLES   4 // extra EX cycles of a mul/div

// stall and flush codes, bit 0 is PC
`define RAM_MEM_STALL    6'b001111
`define RAM_MEM_FLUSH    6'b010000
`define RAM_IF_STALL     6'b001111
`define RAM_IF_FLUSH     6'b000000
`define TRAP_FLUSH_STALL 6'b000010
`define TRAP_FLUSH_FLUSH 6'b001110
`define TRAP_STALL_STALL 6'b111111
`define TRAP_STALL_FLUSH 6'b001110
`define JUMP_STALL       6'b000001
`define JUMP_FLUSH       6'b000110
`define MD_STALL         6'b000111
`define MD_FLUSH         6'b001000
`define LU_STALL         6'b000011
`define LU_FLUSH         6'b000100
`define FETCH_WAIT_STALL 6'b000011
`define FETCH_WAIT_FLUSH 6'b000000
`define RESET_FLUSH      6'b011111

`endif
